// File: dadda_mul_top.f
+incdir+rtl
rtl/mul_pkg.sv
rtl/wb_pkg.sv
rtl/dadda_reduce_stage.sv
rtl/dadda_multiplier.sv
rtl/product_fifo.sv
rtl/wb_mul_slave.sv
rtl/dadda_mul_top.sv
tests/dadda_mul_checker.sv
tests/dadda_mul_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --assert -j 0
TOP      = dadda_mul_tb
FILELIST = dadda_mul_top.f
OBJ_DIR  = obj_dir
RUN_ARGS = +verilator+error+limit+1000
PASS_MSG = No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/dadda_mul_tb.sv
`include "dadda_config.svh"

module dadda_mul_tb;

    logic              clk;
    logic              reset;
    wb_pkg::wb_req_t   wb_req;
    wb_pkg::wb_rsp_t   wb_rsp;
    int                value_errors;
    int                timeouts;
    int                polls;
    logic [31:0]       seed;
    logic [31:0]       rd_data;
    logic              seen;
    mul_pkg::product_t expected [$];

    dadda_mul_top u_dadda_mul_top (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic mul_pkg::product_t true_product(input mul_pkg::operand_t a,
                                                       input mul_pkg::operand_t b);
        return mul_pkg::product_t'(a) * mul_pkg::product_t'(b);
    endfunction

    // entered and left one time unit after a rising edge
    task automatic wait_ack(input int limit, output logic acked);
        int n;
        acked = 1'b0;
        n = 0;
        while (!acked && n < limit) begin
            @(posedge clk);
            #1;
            acked = wb_rsp.ack;
            n++;
        end
    endtask

    // ack is sampled on the next edge, request held until then
    task automatic release_bus;
        @(posedge clk);
        #1;
        wb_req = '0;
    endtask

    task automatic write_reg(input wb_pkg::reg_addr_e adr, input logic [31:0] dat,
                             input int limit, output logic acked);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b1;
        wb_req.adr = adr;
        wb_req.dat = dat;
        wait_ack(limit, acked);
        release_bus();
    endtask

    task automatic read_reg(input wb_pkg::reg_addr_e adr, output logic [31:0] dat);
        logic acked;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b0;
        wb_req.adr = adr;
        wb_req.dat = '0;
        wait_ack(100, acked);
        dat = acked ? wb_rsp.dat : '0;
        release_bus();
        if (!acked) begin
            timeouts++;
            $display("timeout: read of register %s never finished", adr.name());
        end
    endtask

    task automatic send_operands(input mul_pkg::operand_t a, input mul_pkg::operand_t b);
        logic acked;
        write_reg(wb_pkg::reg_operands, {b, a}, 100, acked);
        if (acked) begin
            expected.push_back(true_product(a, b));
        end else begin
            timeouts++;
            $display("timeout: operand write %h x %h was never acknowledged", a, b);
        end
    endtask

    task automatic send_random;
        mul_pkg::operand_t a;
        seed = lcg_step(seed);
        a = seed[31:16];
        seed = lcg_step(seed);
        send_operands(a, seed[31:16]);
    endtask

    // oldest outstanding product comes back first
    task automatic check_result;
        logic [31:0]       got;
        mul_pkg::product_t exp_value;
        exp_value = expected.pop_front();
        read_reg(wb_pkg::reg_result, got);
        assert (got == exp_value) else begin
            value_errors++;
            $display("** Error at time %0t: result %h, expected %h", $time, got, exp_value);
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        wb_req = '0;
        value_errors = 0;
        timeouts = 0;
        seed = 32'd81598;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;
        assert (!wb_rsp.ack) else begin
            value_errors++;
            $display("** Error at time %0t: ack high right after reset", $time);
        end
        read_reg(wb_pkg::reg_status, rd_data);
        assert (rd_data == '0) else begin
            value_errors++;
            $display("** Error at time %0t: status %h after reset, expected 0", $time, rd_data);
        end

        // read issued while the product is still in the pipeline
        send_random();
        check_result();

        seed = lcg_step(seed);
        send_operands('0, seed[31:16]);
        check_result();
        send_operands(16'hffff, 16'hffff);
        check_result();
        send_operands(16'h0001, 16'hffff);
        check_result();

        for (int i = 0; i < 20; i++) begin
            send_random();
            check_result();
        end

        repeat (4) send_random();
        repeat (4) check_result();

        // every credit taken, then one write too many
        repeat (4) send_random();
        polls = 0;
        rd_data = '0;
        while (rd_data[7:0] != 8'd4 && polls < 20) begin
            read_reg(wb_pkg::reg_status, rd_data);
            polls++;
        end
        assert (rd_data == 32'd4) else begin
            value_errors++;
            $display("** Error at time %0t: status %h, expected 4 stored, none in flight",
                     $time, rd_data);
        end
        seed = lcg_step(seed);
        write_reg(wb_pkg::reg_operands, seed, 20, seen);
        assert (!seen) else begin
            value_errors++;
            $display("** Error at time %0t: operand write acked with the FIFO full", $time);
        end
        check_result();
        send_operands(seed[15:0], seed[31:16]);
        repeat (4) check_result();

        $display("value errors: %0d, timeouts: %0d, assertion failures: %0d",
                 value_errors, timeouts, u_dadda_mul_top.u_dadda_mul_checker.failures);
        if (value_errors + timeouts + u_dadda_mul_top.u_dadda_mul_checker.failures == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: tests/dadda_mul_checker.sv
`include "dadda_config.svh"

module dadda_mul_checker (
    input logic                                  clk,
    input logic                                  reset,
    input wb_pkg::wb_req_t                       wb_req,
    input wb_pkg::wb_rsp_t                       wb_rsp,
    input mul_pkg::mul_job_t                     job,
    input mul_pkg::product_t                     product,
    input logic                                  product_valid,
    input logic [$clog2(`PROD_FIFO_DEPTH+1)-1:0] fifo_count,
    input logic [$clog2(`PROD_FIFO_DEPTH+1)-1:0] in_flight
);

    // failed assertions so far, read by the testbench at the end
    int failures = 0;

    a_ack_in_reset: assert property (@(posedge clk) reset |=> !wb_rsp.ack)
        else begin
            failures++;
            $error("ack high while reset is asserted");
        end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else begin
            failures++;
            $error("ack high without cyc and stb");
        end

    a_ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            failures++;
            $error("ack high for two cycles in a row");
        end

    // job edge to product_valid is the full pipeline depth
    a_valid_latency: assert property (@(posedge clk) disable iff (reset)
        product_valid == $past(job.valid, `MUL_LATENCY))
        else begin
            failures++;
            $error("product_valid does not follow the job valid bit");
        end

    a_product_value: assert property (@(posedge clk) disable iff (reset)
        product_valid |-> product ==
            mul_pkg::product_t'($past(job.a, `MUL_LATENCY)) *
            mul_pkg::product_t'($past(job.b, `MUL_LATENCY)))
        else begin
            failures++;
            $error("product differs from the job operands");
        end

    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        (int'(in_flight) + int'(fifo_count)) <= `PROD_FIFO_DEPTH)
        else begin
            failures++;
            $error("in-flight plus FIFO count above the FIFO depth");
        end

endmodule

bind dadda_mul_top dadda_mul_checker u_dadda_mul_checker (
    .clk           (clk),
    .reset         (reset),
    .wb_req        (wb_req),
    .wb_rsp        (wb_rsp),
    .job           (job),
    .product       (product),
    .product_valid (product_valid),
    .fifo_count    (fifo_count),
    .in_flight     (u_wb_mul_slave.in_flight)
);

// File: rtl/dadda_mul_top.sv
`include "dadda_config.svh"

module dadda_mul_top (
    input  logic            clk,
    input  logic            reset,
    input  wb_pkg::wb_req_t wb_req,
    output wb_pkg::wb_rsp_t wb_rsp
);

    mul_pkg::mul_job_t job;
    mul_pkg::product_t product;
    mul_pkg::product_t fifo_head;
    logic              product_valid;
    logic              pop;
    logic [$clog2(`PROD_FIFO_DEPTH+1)-1:0] fifo_count;

    // bus side, launches jobs and drains results
    wb_mul_slave u_wb_mul_slave (
        .clk        (clk),
        .reset      (reset),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .job        (job),
        .fifo_head  (fifo_head),
        .fifo_count (fifo_count),
        .pop        (pop)
    );

    dadda_multiplier u_dadda_multiplier (
        .clk           (clk),
        .reset         (reset),
        .job           (job),
        .product       (product),
        .product_valid (product_valid)
    );

    product_fifo u_product_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (product_valid),
        .push_data (product),
        .pop       (pop),
        .head      (fifo_head),
        .count     (fifo_count)
    );

endmodule

// File: rtl/wb_mul_slave.sv
`include "dadda_config.svh"

module wb_mul_slave (
    input  logic                                  clk,
    input  logic                                  reset,
    input  wb_pkg::wb_req_t                       wb_req,
    output wb_pkg::wb_rsp_t                       wb_rsp,
    output mul_pkg::mul_job_t                     job,
    input  mul_pkg::product_t                     fifo_head,
    input  logic [$clog2(`PROD_FIFO_DEPTH+1)-1:0] fifo_count,
    output logic                                  pop
);

    localparam int cnt_w = $clog2(`PROD_FIFO_DEPTH + 1);

    wb_pkg::slave_state_e state;
    wb_pkg::slave_state_e state_next;
    logic                      req_live;
    logic                      credit_free;
    logic                      launch;
    logic                      ack_next;
    logic [`WB_DATA_WIDTH-1:0] dat_next;
    logic [`WB_DATA_WIDTH-1:0] status_word;
    logic [cnt_w-1:0]          in_flight;
    logic [`MUL_LATENCY-1:0]   launch_sr;

    assign req_live = wb_req.cyc && wb_req.stb;

    // a job on its way in also holds a credit
    assign credit_free = (int'(in_flight) + int'(job.valid) + int'(fifo_count))
                         < `PROD_FIFO_DEPTH;

    always_comb begin
        status_word = '0;
        status_word[7:0]  = 8'(fifo_count);
        status_word[15:8] = 8'(in_flight);
    end

    always_comb begin
        state_next = state;
        ack_next   = 1'b0;
        dat_next   = '0;
        launch     = 1'b0;
        pop        = 1'b0;
        case (state)
            wb_pkg::idle: begin
                // skip the cycle where the last ack is still out
                if (req_live && !wb_rsp.ack) begin
                    state_next = wb_pkg::ack_cycle;
                end
            end
            wb_pkg::ack_cycle: begin
                if (!req_live) begin
                    state_next = wb_pkg::idle;
                end else begin
                    case (wb_pkg::reg_addr_e'(wb_req.adr))
                        wb_pkg::reg_operands: begin
                            if (!wb_req.we || credit_free) begin
                                launch     = wb_req.we;
                                ack_next   = 1'b1;
                                state_next = wb_pkg::idle;
                            end
                        end
                        wb_pkg::reg_result: begin
                            if (wb_req.we) begin
                                ack_next   = 1'b1;
                                state_next = wb_pkg::idle;
                            end else if (fifo_count != '0) begin
                                pop        = 1'b1;
                                ack_next   = 1'b1;
                                dat_next   = fifo_head;
                                state_next = wb_pkg::idle;
                            end else begin
                                state_next = wb_pkg::wait_result;
                            end
                        end
                        wb_pkg::reg_status: begin
                            ack_next   = 1'b1;
                            dat_next   = wb_req.we ? '0 : status_word;
                            state_next = wb_pkg::idle;
                        end
                        default: begin
                            ack_next   = 1'b1;
                            state_next = wb_pkg::idle;
                        end
                    endcase
                end
            end
            wb_pkg::wait_result: begin
                if (!req_live) begin
                    state_next = wb_pkg::idle;
                end else if (fifo_count != '0) begin
                    pop        = 1'b1;
                    ack_next   = 1'b1;
                    dat_next   = fifo_head;
                    state_next = wb_pkg::idle;
                end
            end
            default: state_next = wb_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= wb_pkg::idle;
            wb_rsp.ack <= 1'b0;
            job.valid  <= 1'b0;
            in_flight  <= '0;
            launch_sr  <= '0;
        end else begin
            state      <= state_next;
            wb_rsp.ack <= ack_next;
            job.valid  <= launch;
            // counted from the job edge until the push into the FIFO
            launch_sr  <= {launch_sr[`MUL_LATENCY-2:0], job.valid};
            in_flight  <= in_flight + cnt_w'(job.valid) - cnt_w'(launch_sr[`MUL_LATENCY-1]);
        end
        if (ack_next) begin
            wb_rsp.dat <= dat_next;
        end
        if (launch) begin
            job.a <= wb_req.dat[`MUL_WIDTH-1:0];
            job.b <= wb_req.dat[2*`MUL_WIDTH-1:`MUL_WIDTH];
        end
    end

endmodule

// File: rtl/product_fifo.sv
`include "dadda_config.svh"

module product_fifo #(
    parameter int depth = `PROD_FIFO_DEPTH
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       push,
    input  mul_pkg::product_t          push_data,
    input  logic                       pop,
    output mul_pkg::product_t          head,
    output logic [$clog2(depth+1)-1:0] count
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    mul_pkg::product_t mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;

    // wrap at depth, which need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        logic [ptr_w-1:0] nxt;
        nxt = (int'(ptr) == depth - 1) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // oldest entry
    assign head = mem[rd_ptr];

endmodule

// File: rtl/dadda_multiplier.sv
`include "dadda_config.svh"

module dadda_multiplier (
    input  logic              clk,
    input  logic              reset,
    input  mul_pkg::mul_job_t job,
    output mul_pkg::product_t product,
    output logic              product_valid
);

    localparam int mw = `MUL_WIDTH;
    localparam int pw = `PROD_WIDTH;
    // index of 13, the largest Dadda limit below a 16 bit column
    localparam int top_idx = 5;

    mul_pkg::dot_array_t pp;
    mul_pkg::dot_array_t early_dots [4];
    mul_pkg::dot_array_t late_dots [4];
    mul_pkg::dot_array_t early_q;
    mul_pkg::product_t   row_a;
    mul_pkg::product_t   row_b;
    mul_pkg::product_t   row_a_q;
    mul_pkg::product_t   row_b_q;
    logic [`MUL_LATENCY-1:0] valid_q;

    // AND array, each column packed from bit 0 up
    always_comb begin
        pp = '0;
        for (int i = 0; i < mw; i++) begin
            for (int j = 0; j < mw; j++) begin
                if (i + j < mw) begin
                    pp[i+j][i] = job.a[i] & job.b[j];
                end else begin
                    pp[i+j][mw-1-j] = job.a[i] & job.b[j];
                end
            end
        end
    end

    assign early_dots[0] = pp;

    // 16 -> 13 -> 9 -> 6
    for (genvar s = 0; s < 3; s++) begin : g_early
        dadda_reduce_stage #(
            .limit_in  ((s == 0) ? mw : mul_pkg::dadda_limit(top_idx + 1 - s)),
            .limit_out (mul_pkg::dadda_limit(top_idx - s))
        ) u_stage (
            .dots_in  (early_dots[s]),
            .dots_out (early_dots[s+1])
        );
    end

    assign late_dots[0] = early_q;

    // 6 -> 4 -> 3 -> 2
    for (genvar s = 0; s < 3; s++) begin : g_late
        dadda_reduce_stage #(
            .limit_in  (mul_pkg::dadda_limit(top_idx - 2 - s)),
            .limit_out (mul_pkg::dadda_limit(top_idx - 3 - s))
        ) u_stage (
            .dots_in  (late_dots[s]),
            .dots_out (late_dots[s+1])
        );
    end

    always_comb begin
        for (int c = 0; c < pw; c++) begin
            row_a[c] = late_dots[3][c][0];
            row_b[c] = late_dots[3][c][1];
        end
    end

    always_ff @(posedge clk) begin
        early_q <= early_dots[3];
        row_a_q <= row_a;
        row_b_q <= row_b;
        product <= row_a_q + row_b_q;
    end

    // valid bit follows the job through every stage
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q[mul_pkg::stage_early] <= job.valid;
            valid_q[mul_pkg::stage_late]  <= valid_q[mul_pkg::stage_early];
            valid_q[mul_pkg::stage_add]   <= valid_q[mul_pkg::stage_late];
        end
    end

    assign product_valid = valid_q[mul_pkg::stage_add];

endmodule

// File: rtl/dadda_reduce_stage.sv
`include "dadda_config.svh"

module dadda_reduce_stage #(
    parameter int limit_in  = 13,
    parameter int limit_out = 9
) (
    input  mul_pkg::dot_array_t dots_in,
    output mul_pkg::dot_array_t dots_out
);

    localparam int pw = `PROD_WIDTH;
    localparam int mw = `MUL_WIDTH;

    function automatic logic [pw-1:0][7:0] heights_for(input int limit);
        logic [pw-1:0][7:0] hs;
        for (int c = 0; c < pw; c++) begin
            hs[c] = 8'(mul_pkg::column_height(c, limit));
        end
        return hs;
    endfunction

    // live bits per incoming column
    localparam logic [pw-1:0][7:0] h_in = heights_for(limit_in);

    always_comb begin
        logic [mw-1:0] cin_bits;
        logic [mw-1:0] cout_bits;
        logic x;
        logic y;
        logic z;
        int cin_n;
        int cout_n;
        int h;
        int excess;
        int pos;
        int out_n;
        dots_out = '0;
        cin_bits = '0;
        cin_n = 0;
        for (int col = 0; col < pw; col++) begin
            h = int'(h_in[col]);
            excess = h + cin_n - limit_out;
            pos = 0;
            out_n = 0;
            cout_bits = '0;
            cout_n = 0;
            // full adders take two bits off, a half adder one
            for (int k = 0; k < mw / 2; k++) begin
                if (excess >= 2 && pos + 3 <= h) begin
                    x = dots_in[col][pos];
                    y = dots_in[col][pos+1];
                    z = dots_in[col][pos+2];
                    dots_out[col][out_n] = x ^ y ^ z;
                    cout_bits[cout_n] = (x & y) | (y & z) | (x & z);
                    pos += 3;
                    out_n++;
                    cout_n++;
                    excess -= 2;
                end else if (excess == 1 && pos + 2 <= h) begin
                    x = dots_in[col][pos];
                    y = dots_in[col][pos+1];
                    dots_out[col][out_n] = x ^ y;
                    cout_bits[cout_n] = x & y;
                    pos += 2;
                    out_n++;
                    cout_n++;
                    excess -= 1;
                end
            end
            // untouched bits pass straight down
            for (int k = 0; k < mw; k++) begin
                if (k >= pos && k < h) begin
                    dots_out[col][out_n] = dots_in[col][k];
                    out_n++;
                end
            end
            // carries from the column below sit on top
            for (int k = 0; k < mw; k++) begin
                if (k < cin_n) begin
                    dots_out[col][out_n] = cin_bits[k];
                    out_n++;
                end
            end
            cin_bits = cout_bits;
            cin_n = cout_n;
        end
    end

endmodule

// File: rtl/wb_pkg.sv
`include "dadda_config.svh"

package wb_pkg;

    typedef struct packed {
        logic                      cyc;
        logic                      stb;
        logic                      we;
        logic [`WB_ADDR_WIDTH-1:0] adr;
        logic [`WB_DATA_WIDTH-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                      ack;
        logic [`WB_DATA_WIDTH-1:0] dat;
    } wb_rsp_t;

    // register map
    typedef enum logic [`WB_ADDR_WIDTH-1:0] {
        reg_operands = 0,
        reg_result   = 1,
        reg_status   = 2
    } reg_addr_e;

    typedef enum logic [1:0] {
        idle,
        ack_cycle,
        wait_result
    } slave_state_e;

endpackage

// File: rtl/mul_pkg.sv
`include "dadda_config.svh"

package mul_pkg;

    typedef logic [`MUL_WIDTH-1:0] operand_t;
    typedef logic [`PROD_WIDTH-1:0] product_t;

    typedef struct packed {
        operand_t a;
        operand_t b;
        logic     valid;
    } mul_job_t;

    // one column per product bit, live bits packed at the bottom
    typedef logic [`PROD_WIDTH-1:0][`MUL_WIDTH-1:0] dot_array_t;

    typedef enum logic [1:0] {
        stage_early,
        stage_late,
        stage_add
    } mul_stage_e;

    // 2, 3, 4, 6, 9, 13, 19 ...
    function automatic int dadda_limit(input int idx);
        int d;
        d = 2;
        for (int i = 0; i < 16; i++) begin
            if (i < idx) begin
                d = d * 3 / 2;
            end
        end
        return d;
    endfunction

    // height of a column once every limit down to the given one is applied
    function automatic int column_height(input int col, input int limit);
        int h [`PROD_WIDTH];
        int carry;
        int total;
        int cur;
        for (int c = 0; c < `PROD_WIDTH; c++) begin
            h[c] = (c < `MUL_WIDTH) ? c + 1 : 2 * `MUL_WIDTH - 1 - c;
        end
        for (int s = 15; s >= 0; s--) begin
            cur = dadda_limit(s);
            if (cur < `MUL_WIDTH && cur >= limit) begin
                carry = 0;
                for (int c = 0; c < `PROD_WIDTH; c++) begin
                    total = h[c] + carry;
                    // one carry per full or half compression
                    carry = (total > cur) ? (total - cur + 1) / 2 : 0;
                    h[c] = (total > cur) ? cur : total;
                end
            end
        end
        return h[col];
    endfunction

endpackage

// File: rtl/dadda_config.svh
`ifndef DADDA_CONFIG_SVH
`define DADDA_CONFIG_SVH

// operand and product widths
`define MUL_WIDTH 16
`define PROD_WIDTH (2 * `MUL_WIDTH)

// products held between the pipeline and the bus
`define PROD_FIFO_DEPTH 4

// register file and bus data
`define WB_ADDR_WIDTH 4
`define WB_DATA_WIDTH 32

// register stages in the multiplier
`define MUL_LATENCY 3

`endif
